/* rtl/video_pkg.sv */
`default_nettype none

package video_pkg;

    //////////////////////////////////////////////////
    // 800x600 raster, 1056 x 628 total
    //////////////////////////////////////////////////
    localparam int H_TOTAL = 1056;     // cycles per line
    localparam int H_SYNC  = 128;      // hs low at line start
    localparam int V_TOTAL = 628;      // lines per frame
    localparam int V_SYNC  = 4;        // vs low at frame start

    // image window, counted from line start and frame start
    localparam int IMG_H0 = 220;
    localparam int IMG_V0 = 380;
    localparam int IMG_W  = 320;
    localparam int IMG_H  = 240;

    typedef logic [10:0] hcount_t;     // horizontal position
    typedef logic [10:0] vcount_t;     // line number
    typedef logic [3:0]  rgb4_t;       // one output colour channel

endpackage

`default_nettype wire

/* rtl/frame_pkg.sv */
`default_nettype none

package frame_pkg;

    localparam int FB_DEPTH = 76800;   // 320 x 240 pixels

    typedef logic [16:0] fb_addr_t;
    typedef logic [15:0] pixel_t;      // rgb565
    typedef logic [4:0]  chan_t;       // 5-bit channel for classing
    typedef logic [2:0]  px_class_t;   // brightness order class, 0..6
    typedef logic [16:0] change_cnt_t;

    //////////////////////////////////////////////////
    // frame buffer buses
    //////////////////////////////////////////////////

    // raster read, always served
    typedef struct packed {
        logic     valid;
        fb_addr_t addr;
    } fb_rd_req_t;

    // one cycle after the request, address echoed
    typedef struct packed {
        logic     valid;
        fb_addr_t addr;
        pixel_t   data;
    } fb_rd_rsp_t;

    // camera write, paired with a ready from the store
    typedef struct packed {
        logic     valid;
        fb_addr_t addr;
        pixel_t   data;
    } fb_wr_req_t;

endpackage

`default_nettype wire

/* rtl/vga_raster.sv */
`default_nettype none

module vga_raster
(
    input  logic                  dclk,
    input  logic                  rst,
    output frame_pkg::fb_rd_req_t rd_req,
    input  frame_pkg::fb_rd_rsp_t rd_rsp,
    output logic                  hs,
    output logic                  vs,
    output video_pkg::rgb4_t      r,
    output video_pkg::rgb4_t      g,
    output video_pkg::rgb4_t      b
);
    import video_pkg::*;
    import frame_pkg::*;

    hcount_t  h_cnt;
    vcount_t  v_cnt;
    fb_addr_t pix_addr;      // next window pixel to fetch
    logic     line_end;
    logic     in_win;
    logic     hs_d1;
    logic     vs_d1;

    //////////////////////////////////////////////////
    // position counters
    //////////////////////////////////////////////////
    assign line_end = (h_cnt == hcount_t'(H_TOTAL - 1));

    always_ff @(posedge dclk)
    begin
        if (rst)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (line_end)
        begin
            h_cnt <= '0;
            if (v_cnt == vcount_t'(V_TOTAL - 1))
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end
        else
            h_cnt <= h_cnt + 1'b1;
    end

    assign in_win = (h_cnt >= hcount_t'(IMG_H0)) && (h_cnt < hcount_t'(IMG_H0 + IMG_W))
                 && (v_cnt >= vcount_t'(IMG_V0)) && (v_cnt < vcount_t'(IMG_V0 + IMG_H));

    //////////////////////////////////////////////////
    // stage 1 syncs and read request, stage 2 outputs
    //////////////////////////////////////////////////
    always_ff @(posedge dclk)
    begin
        if (rst)
        begin
            hs_d1        <= 1'b1;
            vs_d1        <= 1'b1;
            hs           <= 1'b1;
            vs           <= 1'b1;
            rd_req.valid <= 1'b0;
            pix_addr     <= '0;
        end
        else
        begin
            hs_d1 <= (h_cnt >= hcount_t'(H_SYNC));
            vs_d1 <= (v_cnt >= vcount_t'(V_SYNC));
            hs    <= hs_d1;     // lines up with the read data
            vs    <= vs_d1;

            rd_req.valid <= in_win;
            rd_req.addr  <= pix_addr;
            if (in_win)
                pix_addr <= pix_addr + 1'b1;
            else if ((v_cnt == '0) && (h_cnt == '0))
                pix_addr <= '0; // new frame
        end
    end

    // 12-bit colour straight from the response
    always_comb
    begin
        if (rd_rsp.valid)
        begin
            r = rd_rsp.data[15:12];
            g = rd_rsp.data[10:7];
            b = rd_rsp.data[4:1];
        end
        else
        begin
            r = '0;
            g = '0;
            b = '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/cam_capture.sv */
`default_nettype none

module cam_capture
(
    input  logic                  dclk,
    input  logic                  rst,
    input  logic [7:0]            cam_dat,
    input  logic                  cam_valid,
    input  logic                  cam_href,
    input  logic                  cam_vs,
    output frame_pkg::fb_wr_req_t wr_req,
    input  logic                  wr_ready,
    output logic                  cam_overrun
);
    import frame_pkg::*;

    logic       phase;       // 1 once the high byte is held
    logic [7:0] hi_byte;
    fb_addr_t   next_addr;
    logic       byte_ok;
    logic       pair_done;
    logic       in_range;
    logic       still_pending;

    assign byte_ok       = cam_valid && cam_href;
    assign pair_done     = byte_ok && phase;
    assign in_range      = (next_addr < fb_addr_t'(FB_DEPTH));
    assign still_pending = wr_req.valid && !wr_ready;   // not taken this cycle

    always_ff @(posedge dclk)
    begin
        if (rst)
        begin
            phase        <= 1'b0;
            next_addr    <= '0;
            wr_req.valid <= 1'b0;
            cam_overrun  <= 1'b0;
        end
        else
        begin
            // byte pairing, high byte first
            if (!cam_href)
                phase <= 1'b0;
            else if (byte_ok)
                phase <= !phase;
            if (byte_ok && !phase)
                hi_byte <= cam_dat;

            // address restarts at camera vsync
            if (cam_vs && !cam_href)
            begin
                next_addr   <= '0;
                cam_overrun <= 1'b0;
            end
            else if (pair_done && in_range)
                next_addr <= next_addr + 1'b1;

            if (pair_done && still_pending)
                cam_overrun <= 1'b1;                    // new pixel lost

            //////////////////////////////////////////////////
            // single pending write
            //////////////////////////////////////////////////
            if (pair_done && !still_pending && in_range)
            begin
                wr_req.valid <= 1'b1;
                wr_req.addr  <= next_addr;
                wr_req.data  <= {hi_byte, cam_dat};
            end
            else if (wr_ready)
                wr_req.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/frame_store.sv */
`default_nettype none

module frame_store
(
    input  logic                  dclk,
    input  logic                  rst,
    input  frame_pkg::fb_rd_req_t rd_req,
    output frame_pkg::fb_rd_rsp_t rd_rsp,
    input  frame_pkg::fb_wr_req_t wr_req,
    output logic                  wr_ready
);
    import frame_pkg::*;

    pixel_t   mem [FB_DEPTH];
    fb_addr_t port_addr;
    logic     wr_en;
    logic     rsp_valid;
    fb_addr_t rsp_addr;
    pixel_t   rsp_data;

    // raster owns the port whenever it asks
    assign wr_ready  = !rst && !rd_req.valid;
    assign wr_en     = wr_req.valid && wr_ready;
    assign port_addr = rd_req.valid ? rd_req.addr : wr_req.addr;

    //////////////////////////////////////////////////
    // single port array
    //////////////////////////////////////////////////
    always_ff @(posedge dclk)
    begin
        if (wr_en)
            mem[port_addr] <= wr_req.data;
        rsp_data <= mem[port_addr];
    end

    always_ff @(posedge dclk)
    begin
        if (rst)
            rsp_valid <= 1'b0;
        else
        begin
            rsp_valid <= rd_req.valid;
            rsp_addr  <= rd_req.addr;   // echoed with the data
        end
    end

    assign rd_rsp = '{valid: rsp_valid, addr: rsp_addr, data: rsp_data};

endmodule

`default_nettype wire

/* rtl/motion_analyzer.sv */
`default_nettype none

module motion_analyzer
(
    input  logic                   dclk,
    input  logic                   rst,
    input  frame_pkg::fb_rd_rsp_t  rd_rsp,
    output frame_pkg::change_cnt_t change_count,
    output logic                   change_valid
);
    import video_pkg::*;
    import frame_pkg::*;

    typedef enum logic {PRIME, RUN} an_state_t;

    an_state_t   state;
    chan_t       red;
    chan_t       green;
    chan_t       blue;
    px_class_t   cur_class;
    px_class_t   class_mem [FB_DEPTH];   // class of each pixel, last frame
    px_class_t   prev_class;
    px_class_t   s1_class;
    fb_addr_t    s1_addr;
    logic        s1_valid;
    logic        px_changed;
    logic        frame_done;
    change_cnt_t run_count;

    assign red   = rd_rsp.data[15:11];
    assign green = rd_rsp.data[10:6];
    assign blue  = rd_rsp.data[4:0];

    //////////////////////////////////////////////////
    // brightness order class
    //////////////////////////////////////////////////
    always_comb
    begin
        if ((red > green) && (green > blue))
            cur_class = 3'd6;
        else if ((red > blue) && (blue > green))
            cur_class = 3'd5;
        else if ((green > blue) && (blue > red))
            cur_class = 3'd4;
        else if ((green > red) && (red > blue))
            cur_class = 3'd3;
        else if ((blue > green) && (green > red))
            cur_class = 3'd2;
        else if ((blue > red) && (red > green))
            cur_class = 3'd1;
        else
            cur_class = 3'd0;   // ties land here
    end

    // lookup now, compare and write back next cycle
    always_ff @(posedge dclk)
    begin
        prev_class <= class_mem[rd_rsp.addr];
        s1_class   <= cur_class;
        s1_addr    <= rd_rsp.addr;
        if (s1_valid)
            class_mem[s1_addr] <= s1_class;
    end

    assign px_changed = s1_valid && (prev_class != s1_class);
    assign frame_done = s1_valid && (s1_addr == fb_addr_t'(IMG_W * IMG_H - 1));

    //////////////////////////////////////////////////
    // per frame count
    //////////////////////////////////////////////////
    always_ff @(posedge dclk)
    begin
        if (rst)
        begin
            state        <= PRIME;
            s1_valid     <= 1'b0;
            run_count    <= '0;
            change_valid <= 1'b0;
        end
        else
        begin
            s1_valid     <= rd_rsp.valid;
            change_valid <= 1'b0;
            if (frame_done)
            begin
                change_count <= run_count + change_cnt_t'(px_changed);
                change_valid <= (state == RUN);  // first frame has no history
                run_count    <= '0;
                state        <= RUN;
            end
            else if (px_changed)
                run_count <= run_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/cam_display_top.sv */
`default_nettype none

module cam_display_top
(
    input  logic                   dclk,
    input  logic                   rst,
    input  logic [7:0]             cam_dat,
    input  logic                   cam_valid,
    input  logic                   cam_href,
    input  logic                   cam_vs,
    output logic                   hs,
    output logic                   vs,
    output video_pkg::rgb4_t       r,
    output video_pkg::rgb4_t       g,
    output video_pkg::rgb4_t       b,
    output frame_pkg::change_cnt_t change_count,
    output logic                   change_valid,
    output logic                   cam_overrun
);
    import frame_pkg::*;

    fb_rd_req_t rd_req;
    fb_rd_rsp_t rd_rsp;     // shared by raster and analyser
    fb_wr_req_t wr_req;
    logic       wr_ready;

    //////////////////////////////////////////////////
    // display side
    //////////////////////////////////////////////////
    vga_raster u_vga_raster
    (
        .dclk   (dclk),
        .rst    (rst),
        .rd_req (rd_req),
        .rd_rsp (rd_rsp),
        .hs     (hs),
        .vs     (vs),
        .r      (r),
        .g      (g),
        .b      (b)
    );

    motion_analyzer u_motion_analyzer
    (
        .dclk         (dclk),
        .rst          (rst),
        .rd_rsp       (rd_rsp),
        .change_count (change_count),
        .change_valid (change_valid)
    );

    //////////////////////////////////////////////////
    // camera side and buffer
    //////////////////////////////////////////////////
    cam_capture u_cam_capture
    (
        .dclk        (dclk),
        .rst         (rst),
        .cam_dat     (cam_dat),
        .cam_valid   (cam_valid),
        .cam_href    (cam_href),
        .cam_vs      (cam_vs),
        .wr_req      (wr_req),
        .wr_ready    (wr_ready),
        .cam_overrun (cam_overrun)
    );

    frame_store u_frame_store
    (
        .dclk     (dclk),
        .rst      (rst),
        .rd_req   (rd_req),
        .rd_rsp   (rd_rsp),
        .wr_req   (wr_req),
        .wr_ready (wr_ready)
    );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen
(
    output logic dclk,
    output logic rst
);

    initial
    begin
        dclk = 1'b0;
        forever #5 dclk = ~dclk;    // period 10
    end

    // two cycles of reset
    initial
    begin
        rst = 1'b1;
        repeat (2) @(posedge dclk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* dv/cam_display_tb.sv */
`default_nettype none

module cam_display_tb;
    import video_pkg::*;
    import frame_pkg::*;

    localparam logic [31:0] SEED   = 32'ha3b7_71d8;
    localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_CYCLES = 10 * FRAME_CYCLES;

    logic        dclk;
    logic        rst;
    logic [7:0]  cam_dat;
    logic        cam_valid;
    logic        cam_href;
    logic        cam_vs;
    logic        hs;
    logic        vs;
    rgb4_t       r;
    rgb4_t       g;
    rgb4_t       b;
    change_cnt_t change_count;
    logic        change_valid;
    logic        cam_overrun;

    pixel_t      model [FB_DEPTH];     // expected buffer contents
    bit          picked [FB_DEPTH];    // addresses already changed
    logic        img_check;
    string       cur_test;
    int          err_cnt;
    int          sync_err;
    int          n_tests;
    int          n_failed;
    int          total_err;

    // raster position as seen on hs/vs
    int          cyc;
    int          hpos;
    int          vline;
    int          hs_fall_cyc;
    logic        hs_q;
    logic        vs_q;
    logic        line_seen;
    logic        pos_known;
    int          pulses;
    int          last_pulses;
    change_cnt_t pulse_count;
    change_cnt_t last_count;
    event        frame_start;

    tb_clk_gen u_tb_clk_gen
    (
        .dclk (dclk),
        .rst  (rst)
    );

    cam_display_top u_cam_display_top
    (
        .dclk         (dclk),
        .rst          (rst),
        .cam_dat      (cam_dat),
        .cam_valid    (cam_valid),
        .cam_href     (cam_href),
        .cam_vs       (cam_vs),
        .hs           (hs),
        .vs           (vs),
        .r            (r),
        .g            (g),
        .b            (b),
        .change_count (change_count),
        .change_valid (change_valid),
        .cam_overrun  (cam_overrun)
    );

    //////////////////////////////////////////////////
    // reference rules
    //////////////////////////////////////////////////
    function automatic px_class_t order_class(input pixel_t p);
        chan_t     cr;
        chan_t     cg;
        chan_t     cb;
        px_class_t c;
        cr = p[15:11];
        cg = p[10:6];
        cb = p[4:0];
        if ((cr == cg) || (cg == cb) || (cr == cb))
            return 3'd0;    // any tie
        case ({cr > cg, cg > cb, cr > cb})
            3'b111:  c = 3'd6;
            3'b101:  c = 3'd5;
            3'b010:  c = 3'd4;
            3'b011:  c = 3'd3;
            3'b000:  c = 3'd2;
            3'b100:  c = 3'd1;
            default: c = 3'd0;
        endcase
        return c;
    endfunction

    function automatic pixel_t other_class_pixel(input pixel_t old);
        pixel_t p;
        p = pixel_t'($urandom);
        while (order_class(p) == order_class(old))
            p = pixel_t'($urandom);
        return p;
    endfunction

    // top four bits of each channel
    function automatic logic [11:0] shown_colour(input pixel_t p);
        return {p[15:12], p[10:7], p[4:1]};
    endfunction

    task automatic value_mismatch(input string what, input int exp, input int act);
        err_cnt++;
        $display("[FAIL] %s %s: expected 'h%0h actual 'h%0h", cur_test, what, exp, act);
    endtask

    task automatic sync_mismatch(input string what, input int exp, input int act);
        sync_err++;
        $display("[FAIL] sync %s: expected %0d actual %0d", what, exp, act);
    endtask

    task automatic protocol_fail(input string what);
        sync_err++;
        $display("sync check failed, %s", what);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_cnt  = 0;
    endtask

    task automatic finish_test(input string name, input int errs);
        n_tests++;
        total_err += errs;
        if (errs == 0)
            $display("test %s: ok", name);
        else
        begin
            n_failed++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    task automatic check_report(input int exp);
        assert (last_pulses == 1)
        else value_mismatch("report pulses", 1, last_pulses);
        assert (last_count === change_cnt_t'(exp))
        else value_mismatch("change_count", exp, last_count);
    endtask

    //////////////////////////////////////////////////
    // camera driver
    //////////////////////////////////////////////////
    task automatic send_vsync();
        @(posedge dclk);
        cam_valid <= 1'b0;
        cam_href  <= 1'b0;
        cam_vs    <= 1'b1;
        @(posedge dclk);
        cam_vs    <= 1'b0;
        cam_href  <= 1'b1;
    endtask

    // high byte first with gap idle cycles after each byte
    task automatic send_pixel(input pixel_t p, input int gap);
        @(posedge dclk);
        cam_dat   <= p[15:8];
        cam_valid <= 1'b1;
        repeat (gap)
        begin
            @(posedge dclk);
            cam_valid <= 1'b0;
        end
        @(posedge dclk);
        cam_dat   <= p[7:0];
        cam_valid <= 1'b1;
        repeat (gap)
        begin
            @(posedge dclk);
            cam_valid <= 1'b0;
        end
    endtask

    task automatic end_frame();
        @(posedge dclk);
        cam_valid <= 1'b0;
        cam_href  <= 1'b0;
    endtask

    task automatic send_frame(input int gap);
        int i;
        send_vsync();
        for (i = 0; i < FB_DEPTH; i++)
            send_pixel(model[i], gap);
        end_frame();
    endtask

    //////////////////////////////////////////////////
    // output monitor sampled mid cycle
    //////////////////////////////////////////////////
    always @(negedge dclk)
    begin : monitor
        logic        hs_fell;
        logic        vs_fell;
        logic        in_win;
        logic [11:0] exp_rgb;

        cyc = cyc + 1;
        if (!rst)
        begin
            hs_fell = hs_q && !hs;
            vs_fell = vs_q && !vs;
            assert (!vs_fell || hs_fell)
            else protocol_fail("vs fell away from a line start");
            if (hs_fell)
            begin
                if (line_seen)
                begin
                    assert (cyc - hs_fall_cyc == H_TOTAL)
                    else sync_mismatch("hs period", H_TOTAL, cyc - hs_fall_cyc);
                end
                line_seen   = 1'b1;
                hs_fall_cyc = cyc;
                hpos        = 0;
                if (vs_fell)
                begin
                    if (pos_known)
                    begin
                        assert (vline == V_TOTAL - 1)
                        else sync_mismatch("vs period in lines", V_TOTAL, vline + 1);
                    end
                    pos_known = 1'b1;
                    vline     = 0;
                end
                else
                    vline = vline + 1;
            end
            else
                hpos = hpos + 1;

            if (line_seen && !hs_q && hs)
            begin
                assert (hpos == H_SYNC)
                else sync_mismatch("hs low width", H_SYNC, hpos);
            end
            if (pos_known && !vs_q && vs)
            begin
                assert (vline == V_SYNC)
                else sync_mismatch("vs low lines", V_SYNC, vline);
            end

            if (pos_known)
            begin
                in_win = (vline >= IMG_V0) && (vline < IMG_V0 + IMG_H)
                      && (hpos >= IMG_H0) && (hpos < IMG_H0 + IMG_W);
                if (!in_win)
                begin
                    assert ({r, g, b} == 12'h000)
                    else sync_mismatch("colour outside window", 0, {r, g, b});
                end
                else if (img_check)
                begin
                    exp_rgb = shown_colour(model[(vline - IMG_V0) * IMG_W + hpos - IMG_H0]);
                    assert ({r, g, b} === exp_rgb)
                    else value_mismatch("window pixel", exp_rgb, {r, g, b});
                end
            end

            if (change_valid)
            begin
                pulses      = pulses + 1;
                pulse_count = change_count;
                assert (vline >= IMG_V0 + IMG_H - 1)
                else protocol_fail("change_valid came before the last window line");
            end
            if (vs_fell)
            begin
                last_pulses = pulses;   // results of the frame just ended
                last_count  = pulse_count;
                pulses      = 0;
                -> frame_start;
            end
        end
        hs_q = hs;
        vs_q = vs;
    end

    // report pulse is one cycle wide
    assert property (@(posedge dclk) disable iff (rst) change_valid |=> !change_valid)
    else protocol_fail("change_valid stayed high for more than one cycle");

    assert property (@(posedge dclk) disable iff (rst) !hs |-> ({r, g, b} == 12'h000))
    else protocol_fail("colour was driven while hs was low");

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge dclk);
        $display("watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // test sequence with one camera step per raster frame
    //////////////////////////////////////////////////
    initial
    begin : stimulus
        int n_chg;
        int addr;
        int i;

        cam_dat     = '0;
        cam_valid   = 1'b0;
        cam_href    = 1'b0;
        cam_vs      = 1'b0;
        img_check   = 1'b0;
        err_cnt     = 0;
        sync_err    = 0;
        n_tests     = 0;
        n_failed    = 0;
        total_err   = 0;
        cyc         = 0;
        hpos        = 0;
        vline       = 0;
        hs_fall_cyc = 0;
        hs_q        = 1'b1;
        vs_q        = 1'b1;
        line_seen   = 1'b0;
        pos_known   = 1'b0;
        pulses      = 0;
        last_pulses = 0;
        void'($urandom(SEED));
        wait (rst === 1'b0);
        @(frame_start);

        // analyser only primes on the first frame
        start_test("image");
        for (i = 0; i < FB_DEPTH; i++)
            model[i] = pixel_t'($urandom);
        send_frame(1);
        img_check = 1'b1;
        @(frame_start);
        img_check = 1'b0;
        assert (last_pulses == 0)
        else value_mismatch("report pulses", 0, last_pulses);
        finish_test(cur_test, err_cnt);

        start_test("change_count");
        n_chg = 1 + ($urandom % 48);
        for (i = 0; i < n_chg; i++)
        begin
            do
                addr = $urandom % FB_DEPTH;
            while (picked[addr]);
            picked[addr] = 1'b1;
            model[addr]  = other_class_pixel(model[addr]);
        end
        send_frame(1);
        img_check = 1'b1;
        @(frame_start);
        img_check = 1'b0;
        check_report(n_chg);
        finish_test(cur_test, err_cnt);

        start_test("repeat");
        img_check = 1'b1;       // buffer untouched
        @(frame_start);
        img_check = 1'b0;
        check_report(0);
        finish_test(cur_test, err_cnt);

        // gapless bytes while the window is read
        start_test("overrun");
        while (vline != IMG_V0 + 10)
            @(posedge dclk);
        send_vsync();
        for (i = 0; i < 1000; i++)
            send_pixel(pixel_t'($urandom), 0);
        end_frame();
        repeat (4) @(posedge dclk);
        assert (cam_overrun === 1'b1)
        else value_mismatch("cam_overrun", 1, cam_overrun);
        @(frame_start);
        finish_test(cur_test, err_cnt);

        start_test("overrun_clear");
        for (i = 0; i < FB_DEPTH; i++)
            model[i] = pixel_t'($urandom);
        send_frame(1);
        repeat (4) @(posedge dclk);
        assert (cam_overrun === 1'b0)
        else value_mismatch("cam_overrun", 0, cam_overrun);
        img_check = 1'b1;
        @(frame_start);
        img_check = 1'b0;
        finish_test(cur_test, err_cnt);

        // partial frame cut short by cam_vs
        start_test("restart");
        send_vsync();
        for (i = 0; i < 1500; i++)
            send_pixel(pixel_t'($urandom), 1);
        for (i = 0; i < FB_DEPTH; i++)
            model[i] = pixel_t'($urandom);
        send_frame(1);
        img_check = 1'b1;
        @(frame_start);
        img_check = 1'b0;
        finish_test(cur_test, err_cnt);

        finish_test("sync", sync_err);
        $display("tests run: %0d, failed: %0d, errors: %0d", n_tests, n_failed, total_err);
        if (n_failed == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/video_pkg.sv
rtl/frame_pkg.sv
rtl/vga_raster.sv
rtl/cam_capture.sv
rtl/frame_store.sv
rtl/motion_analyzer.sv
rtl/cam_display_top.sv
dv/tb_clk_gen.sv
dv/cam_display_tb.sv

/* Bender.yml */
package:
  name: cam_display

sources:
  - rtl/video_pkg.sv
  - rtl/frame_pkg.sv
  - rtl/vga_raster.sv
  - rtl/cam_capture.sv
  - rtl/frame_store.sv
  - rtl/motion_analyzer.sv
  - rtl/cam_display_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/cam_display_tb.sv
